// ==== hw/stream_pkg.sv ====
package stream_pkg;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////

	// Sequence tag carried with every operation
	localparam int TAG_W = 8;

	// Argument and accumulator width
	localparam int ARG_W = 32;

	////////////////////////////////////////////////////////////
	// Operation encoding
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		OP_LOAD  = 2'b00,
		OP_ADD   = 2'b01,
		OP_XOR   = 2'b10,
		OP_CLEAR = 2'b11
	} op_e;

	// One FIFO entry
	typedef struct packed
	{
		op_e              op;
		logic [TAG_W-1:0] tag;
		logic [ARG_W-1:0] arg;
	} cmd_rec_t;

	// One executor output
	typedef struct packed
	{
		logic [TAG_W-1:0] tag;
		logic [ARG_W-1:0] acc;
	} result_t;

	////////////////////////////////////////////////////////////
	// FIFO sizing
	////////////////////////////////////////////////////////////

	localparam int FIFO_AW    = 4;
	localparam int FIFO_DEPTH = 1 << FIFO_AW;
	localparam int AF_MARGIN  = 4;

	// Occupancy at which almost-full is raised
	localparam int AF_LEVEL = FIFO_DEPTH - AF_MARGIN;

	// Memory word width
	localparam int REC_W = $bits(cmd_rec_t);

endpackage

// ==== hw/fifo_ram.sv ====
`timescale 1ns/100ps

module fifo_ram import stream_pkg::*;
(
	input  logic               clk,
	input  logic               wr_en,
	input  logic [FIFO_AW-1:0] wr_addr,
	input  logic [REC_W-1:0]   wr_data,
	input  logic [FIFO_AW-1:0] rd_addr,
	output logic [REC_W-1:0]   rd_data
);

	logic [REC_W-1:0] mem [FIFO_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, a colliding write is seen one cycle later
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== hw/sc_fifo.sv ====
`timescale 1ns/100ps

module sc_fifo import stream_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clr,
	input  logic       wr_en,
	input  cmd_rec_t   wr_rec,
	input  logic       rd_en,
	output cmd_rec_t   rd_rec,
	output logic       empty,
	output logic       full,
	output logic       almost_full,
	output logic [1:0] level
);

	logic [FIFO_AW-1:0] wp;
	logic [FIFO_AW-1:0] rp;
	logic [FIFO_AW:0]   cnt;
	logic [FIFO_AW:0]   cnt_next;
	logic [REC_W-1:0]   ram_q;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	fifo_ram i_fifo_ram
	(
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wp),
		.wr_data (wr_rec),
		.rd_addr (rp),
		.rd_data (ram_q)
	);

	// Word addressed by rp in the read cycle
	assign rd_rec = ram_q;

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wp <= '0;
			rp <= '0;
		end
		else if (clr)
		begin
			wp <= '0;
			rp <= '0;
		end
		else
		begin
			if (wr_en)
				wp <= wp + FIFO_AW'(1);
			if (rd_en)
				rp <= rp + FIFO_AW'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Occupancy and registered flags
	////////////////////////////////////////////////////////////

	// Simultaneous write and read leaves the count alone
	always_comb
	begin
		case ({wr_en, rd_en})
			2'b10:   cnt_next = cnt + 1'b1;
			2'b01:   cnt_next = cnt - 1'b1;
			default: cnt_next = cnt;
		endcase
	end

	// Flags follow the count they will describe next cycle
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			cnt         <= '0;
			empty       <= 1'b1;
			full        <= 1'b0;
			almost_full <= 1'b0;
		end
		else if (clr)
		begin
			cnt         <= '0;
			empty       <= 1'b1;
			full        <= 1'b0;
			almost_full <= 1'b0;
		end
		else
		begin
			cnt         <= cnt_next;
			empty       <= (cnt_next == '0);
			full        <= (cnt_next == (FIFO_AW+1)'(FIFO_DEPTH));
			almost_full <= (cnt_next >= (FIFO_AW+1)'(AF_LEVEL));
		end
	end

	// Coarse fill, pinned at 3 once the count reaches depth
	assign level = cnt[FIFO_AW] ? 2'b11 : cnt[FIFO_AW-1 -: 2];

	////////////////////////////////////////////////////////////
	// Protocol checks on the producer and consumer
	////////////////////////////////////////////////////////////

	property p_no_write_full;
		@(posedge clk) disable iff (!rst)
		wr_en |-> !full;
	endproperty
	a_no_write_full: assert property (p_no_write_full)
		else $error("write while FIFO full");

	property p_no_read_empty;
		@(posedge clk) disable iff (!rst)
		rd_en |-> !empty;
	endproperty
	a_no_read_empty: assert property (p_no_read_empty)
		else $error("read while FIFO empty");

endmodule

// ==== hw/cmd_framer.sv ====
`timescale 1ns/100ps

module cmd_framer import stream_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             clr,
	input  logic             in_valid,
	input  op_e              in_op,
	input  logic [ARG_W-1:0] in_arg,
	input  logic             fifo_full,
	output logic             wr_en,
	output cmd_rec_t         wr_rec,
	output logic             overflow
);

	logic             pend_valid;
	op_e              pend_op;
	logic [ARG_W-1:0] pend_arg;
	logic [TAG_W-1:0] tag;
	logic             drop;
	logic             ovf_sticky;

	// Full is sampled in the write cycle, where it already counts
	// the previous write, so back-to-back arrivals cannot overrun
	assign wr_en    = pend_valid && !fifo_full && !clr;
	assign drop     = pend_valid && fifo_full && !clr;
	assign overflow = ovf_sticky || drop;

	// Tag is attached at write time, dropped operations keep it
	assign wr_rec = '{op: pend_op, tag: tag, arg: pend_arg};

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			pend_valid <= 1'b0;
			tag        <= '0;
			ovf_sticky <= 1'b0;
		end
		else if (clr)
		begin
			pend_valid <= 1'b0;
			tag        <= '0;
			ovf_sticky <= 1'b0;
		end
		else
		begin
			pend_valid <= in_valid;
			if (wr_en)
				tag <= tag + TAG_W'(1);
			if (drop)
				ovf_sticky <= 1'b1;
		end
	end

	// Operation payload, captured on the strobe
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			pend_op  <= in_op;
			pend_arg <= in_arg;
		end
	end

	// Full can only rise right after one of our writes
	property p_full_after_write;
		@(posedge clk) disable iff (!rst)
		$rose(fifo_full) |-> $past(wr_en);
	endproperty
	a_full_after_write: assert property (p_full_after_write)
		else $error("FIFO full rose without a write");

endmodule

// ==== hw/acc_exec.sv ====
`timescale 1ns/100ps

module acc_exec import stream_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     clr,
	input  logic     drain_en,
	input  logic     fifo_empty,
	input  cmd_rec_t rd_rec,
	output logic     rd_en,
	output logic     res_valid,
	output result_t  res
);

	logic             rd_pend;
	logic [ARG_W-1:0] acc;
	logic [ARG_W-1:0] acc_next;
	logic [TAG_W-1:0] res_tag;

	// Empty already reflects the read of the previous cycle,
	// so a last record in flight is never read twice
	assign rd_en = drain_en && !fifo_empty && !clr;

	////////////////////////////////////////////////////////////
	// Opcode datapath
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (rd_rec.op)
			OP_LOAD:  acc_next = rd_rec.arg;
			OP_ADD:   acc_next = acc + rd_rec.arg;
			OP_XOR:   acc_next = acc ^ rd_rec.arg;
			OP_CLEAR: acc_next = '0;
			default:  acc_next = acc;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			rd_pend   <= 1'b0;
			res_valid <= 1'b0;
			acc       <= '0;
		end
		else if (clr)
		begin
			rd_pend   <= 1'b0;
			res_valid <= 1'b0;
			acc       <= '0;
		end
		else
		begin
			rd_pend   <= rd_en;
			res_valid <= rd_pend;
			if (rd_pend)
				acc <= acc_next;
		end
	end

	// Tag of the record just applied
	always_ff @(posedge clk)
	begin
		if (rd_pend)
			res_tag <= rd_rec.tag;
	end

	assign res = '{tag: res_tag, acc: acc};

	// Empty can only rise right after one of our reads or a clear
	property p_empty_after_read;
		@(posedge clk) disable iff (!rst)
		$rose(fifo_empty) |-> ($past(rd_en) || $past(clr));
	endproperty
	a_empty_after_read: assert property (p_empty_after_read)
		else $error("FIFO empty rose without a read");

endmodule

// ==== hw/stream_top.sv ====
`timescale 1ns/100ps

module stream_top import stream_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             clr,
	input  logic             in_valid,
	input  op_e              in_op,
	input  logic [ARG_W-1:0] in_arg,
	input  logic             drain_en,
	output logic             res_valid,
	output result_t          res,
	output logic             fifo_empty,
	output logic             fifo_full,
	output logic             fifo_almost_full,
	output logic [1:0]       fifo_level,
	output logic             overflow
);

	logic     wr_en;
	cmd_rec_t wr_rec;
	logic     rd_en;
	cmd_rec_t rd_rec;

	// Producer
	cmd_framer i_cmd_framer
	(
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.in_valid  (in_valid),
		.in_op     (in_op),
		.in_arg    (in_arg),
		.fifo_full (fifo_full),
		.wr_en     (wr_en),
		.wr_rec    (wr_rec),
		.overflow  (overflow)
	);

	// Buffer
	sc_fifo i_sc_fifo
	(
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.wr_en       (wr_en),
		.wr_rec      (wr_rec),
		.rd_en       (rd_en),
		.rd_rec      (rd_rec),
		.empty       (fifo_empty),
		.full        (fifo_full),
		.almost_full (fifo_almost_full),
		.level       (fifo_level)
	);

	// Consumer
	acc_exec i_acc_exec
	(
		.clk        (clk),
		.rst        (rst),
		.clr        (clr),
		.drain_en   (drain_en),
		.fifo_empty (fifo_empty),
		.rd_rec     (rd_rec),
		.rd_en      (rd_en),
		.res_valid  (res_valid),
		.res        (res)
	);

endmodule

// ==== include/stream_tb_vectors.svh ====
// Columns: in_valid, in_op, in_arg, drain_en, clr, settle cycles,
// then expected fifo_level, empty, full, almost_full, overflow
`ifndef STREAM_TB_VECTORS_SVH
`define STREAM_TB_VECTORS_SVH

localparam int NUM_ROWS = 32;

vec_t vectors [NUM_ROWS] = '{
	// Opcode sequence with draining on
	'{1'b1, OP_LOAD,  32'h0000_1234, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0F00, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_XOR,   32'hFFFF_0000, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0001, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_CLEAR, 32'hDEAD_BEEF, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0010, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	// Fill with draining off, the 17th arrival is dropped
	'{1'b1, OP_ADD,   32'h0000_0001, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0002, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_XOR,   32'h0000_00F0, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0100, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_LOAD,  32'h1000_0000, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0003, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_XOR,   32'h0F00_0000, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0004, 1'b0, 1'b0, 8'd1,  2'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0005, 1'b0, 1'b0, 8'd1,  2'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_XOR,   32'h0000_FFFF, 1'b0, 1'b0, 8'd1,  2'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0006, 1'b0, 1'b0, 8'd1,  2'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0007, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b0, 1'b1, 1'b0},
	'{1'b1, OP_CLEAR, 32'h0000_0000, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b0, 1'b1, 1'b0},
	'{1'b1, OP_ADD,   32'h1234_5678, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b0, 1'b1, 1'b0},
	'{1'b1, OP_XOR,   32'h8000_0001, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b0, 1'b1, 1'b0},
	'{1'b1, OP_ADD,   32'h0000_0008, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b1, 1'b1, 1'b0},
	'{1'b1, OP_LOAD,  32'hFFFF_FFFF, 1'b0, 1'b0, 8'd1,  2'd3, 1'b0, 1'b1, 1'b1, 1'b1},
	// Drain all sixteen, overflow stays set
	'{1'b0, OP_LOAD,  32'h0000_0000, 1'b1, 1'b0, 8'd20, 2'd0, 1'b1, 1'b0, 1'b0, 1'b1},
	// Partly fill, then clear
	'{1'b1, OP_LOAD,  32'hAAAA_0000, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b1},
	'{1'b1, OP_ADD,   32'h0000_0001, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b1},
	'{1'b1, OP_ADD,   32'h0000_0002, 1'b0, 1'b0, 8'd1,  2'd0, 1'b0, 1'b0, 1'b0, 1'b1},
	'{1'b1, OP_XOR,   32'h0000_5555, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b1},
	'{1'b1, OP_ADD,   32'h0000_0003, 1'b0, 1'b0, 8'd1,  2'd1, 1'b0, 1'b0, 1'b0, 1'b1},
	'{1'b0, OP_LOAD,  32'h0000_0000, 1'b0, 1'b1, 8'd1,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	// Tag and accumulator start again from zero
	'{1'b1, OP_ADD,   32'h0000_0005, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0},
	'{1'b1, OP_XOR,   32'h0F0F_0F0F, 1'b1, 1'b0, 8'd5,  2'd0, 1'b1, 1'b0, 1'b0, 1'b0}
};

`endif

// ==== tb/stream_tb.sv ====
`timescale 1ns/100ps

module stream_tb import stream_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_RAND   = 200;

	// One table row, stimulus first, then the status expected after it
	typedef struct packed
	{
		logic             in_valid;
		op_e              op;
		logic [ARG_W-1:0] arg;
		logic             drain_en;
		logic             clr;
		logic [7:0]       settle;
		logic [1:0]       level;
		logic             empty;
		logic             full;
		logic             almost_full;
		logic             overflow;
	} vec_t;

	`include "stream_tb_vectors.svh"

	localparam int WATCHDOG_NS = (NUM_ROWS + NUM_RAND) * 20 * CLK_PERIOD + 1000;

	logic             clk;
	logic             rst;
	logic             clr;
	logic             in_valid;
	op_e              in_op;
	logic [ARG_W-1:0] in_arg;
	logic             drain_en;
	logic             res_valid;
	result_t          res;
	logic             fifo_empty;
	logic             fifo_full;
	logic             fifo_almost_full;
	logic [1:0]       fifo_level;
	logic             overflow;

	// Reference model state
	result_t          exp_q [$];
	logic [TAG_W-1:0] m_tag;
	logic [ARG_W-1:0] m_acc;
	logic             m_ovf;
	int               seed;

	stream_top i_stream_top
	(
		.clk              (clk),
		.rst              (rst),
		.clr              (clr),
		.in_valid         (in_valid),
		.in_op            (in_op),
		.in_arg           (in_arg),
		.drain_en         (drain_en),
		.res_valid        (res_valid),
		.res              (res),
		.fifo_empty       (fifo_empty),
		.fifo_full        (fifo_full),
		.fifo_almost_full (fifo_almost_full),
		.fifo_level       (fifo_level),
		.overflow         (overflow)
	);

	always
	begin
		clk = 1'b0;
		#(CLK_PERIOD/2);
		clk = 1'b1;
		#(CLK_PERIOD/2);
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_status(input logic [1:0] exp_level, input logic exp_empty,
		input logic exp_full, input logic exp_af, input logic exp_ovf);
		if (fifo_level !== exp_level)
		begin
			$display("[ERROR] fifo_level: got %h, expected %h", fifo_level, exp_level);
			stop_run();
		end
		check_bit("fifo_empty", fifo_empty, exp_empty);
		check_bit("fifo_full", fifo_full, exp_full);
		check_bit("fifo_almost_full", fifo_almost_full, exp_af);
		check_bit("overflow", overflow, exp_ovf);
	endtask

	task automatic check_result(input result_t got, input result_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] res: got tag=%h acc=%h, expected tag=%h acc=%h",
				got.tag, got.acc, exp.tag, exp.acc);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	task automatic model_clear();
		exp_q.delete();
		m_tag = '0;
		m_acc = '0;
		m_ovf = 1'b0;
	endtask

	// Accepted while fewer than FIFO_DEPTH records are outstanding
	task automatic model_offer(input op_e op, input logic [ARG_W-1:0] arg);
		result_t rec;
		if (exp_q.size() < FIFO_DEPTH)
		begin
			case (op)
				OP_LOAD: m_acc = arg;
				OP_ADD:  m_acc = m_acc + arg;
				OP_XOR:  m_acc = m_acc ^ arg;
				default: m_acc = '0;
			endcase
			rec.tag = m_tag;
			rec.acc = m_acc;
			exp_q.push_back(rec);
			m_tag = m_tag + TAG_W'(1);
		end
		else
			m_ovf = 1'b1;
	endtask

	// Every result strobe must match the oldest predicted result
	always @(negedge clk)
	begin
		if (rst && res_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Result strobe with tag %h arrived when none was expected", res.tag);
				stop_run();
			end
			else
				check_result(res, exp_q.pop_front());
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive(input logic valid, input op_e op, input logic [ARG_W-1:0] arg,
		input logic drain, input logic clear);
		in_valid <= valid;
		in_op    <= op;
		in_arg   <= arg;
		drain_en <= drain;
		clr      <= clear;
	endtask

	task automatic release_reset();
		rst <= 1'b1;
	endtask

	task automatic wait_drained(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Expected result with tag %h never arrived", exp_q[0].tag);
			stop_run();
		end
	endtask

	task automatic apply_row(input vec_t v);
		@(posedge clk);
		drive(v.in_valid, v.op, v.arg, v.drain_en, v.clr);
		if (v.clr)
			model_clear();
		else if (v.in_valid)
			model_offer(v.op, v.arg);
		@(posedge clk);
		drive(1'b0, v.op, v.arg, v.drain_en, 1'b0);
		repeat (v.settle) @(posedge clk);
		@(negedge clk);
		if (v.drain_en)
		begin
			wait_drained(4 * FIFO_DEPTH);
			@(negedge clk);
		end
		check_status(v.level, v.empty, v.full, v.almost_full, v.overflow);
		check_bit("overflow", overflow, m_ovf);
	endtask

	// Random traffic, arrivals held back so the model never sees a drop
	task automatic run_random();
		int               r;
		logic             drain;
		logic             valid;
		logic [ARG_W-1:0] arg;
		drain = 1'b1;
		for (int i = 0; i < NUM_RAND; i++)
		begin
			@(posedge clk);
			r   = $random(seed);
			arg = $random(seed);
			if (r[3:2] == 2'b00)
				drain = ~drain;
			valid = r[0] && (exp_q.size() < FIFO_DEPTH);
			drive(valid, op_e'(r[5:4]), arg, drain, 1'b0);
			if (valid)
				model_offer(op_e'(r[5:4]), arg);
			@(negedge clk);
			check_bit("overflow", overflow, 1'b0);
		end
		@(posedge clk);
		drive(1'b0, OP_LOAD, '0, 1'b1, 1'b0);
		wait_drained(4 * FIFO_DEPTH);
		@(negedge clk);
		check_status(2'd0, 1'b1, 1'b0, 1'b0, 1'b0);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		stop_run();
	end

	initial
	begin
		seed     = 49;
		rst      = 1'b0;
		clr      = 1'b0;
		in_valid = 1'b0;
		in_op    = OP_LOAD;
		in_arg   = '0;
		drain_en = 1'b0;
		model_clear();
		repeat (3) @(posedge clk);
		release_reset();

		// Idle state after reset
		@(negedge clk);
		check_status(2'd0, 1'b1, 1'b0, 1'b0, 1'b0);
		repeat (4)
		begin
			@(negedge clk);
			check_bit("res_valid", res_valid, 1'b0);
		end

		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(vectors[i]);

		run_random();

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hw/stream_pkg.sv
hw/fifo_ram.sv
hw/sc_fifo.sv
hw/cmd_framer.sv
hw/acc_exec.sv
hw/stream_top.sv
tb/stream_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

# Build the testbench with the RTL from the file list
verilator --binary --timing --assert -f verilog.f --top-module stream_tb

# Run, show the output, then look for the pass line
out=$(./obj_dir/Vstream_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -Fxq "All tests passed!"
